// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_output_writer
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cq_demux.sv
`timescale 1ns/1ps

module cq_demux (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [out_writer_pkg::STRM_ID_W-1:0] cq_data,   // owning stream id.
  input  logic                                 cq_valid,
  output logic [out_writer_pkg::N_STRM-1:0]    cpl_valid  // one strobe per writer.
);

  // ****************************************
  // id decode
  // ****************************************
  always_comb begin
    for (int s = 0; s < out_writer_pkg::N_STRM; s++) begin
      cpl_valid[s] = cq_valid && (int'(cq_data) == s);  // no ready, writer always takes it.
    end
  end

  // a completion for a missing stream would be lost silently.
  a_id_range: assert property (@(posedge clk) disable iff (!rst_n)
    cq_valid |-> int'(cq_data) < out_writer_pkg::N_STRM)
    else $error("completion for unknown stream %0d.", cq_data);

endmodule

// File: filelist.f
out_writer_pkg.sv
stream_writer.sv
rr_arbiter.sv
cq_demux.sv
output_writer.sv
tb_clk_gen.sv
tb_output_writer.sv

// File: out_writer_pkg.sv
package out_writer_pkg;

  // ****************************************
  // stream and bus sizes
  // ****************************************
  localparam int N_STRM    = 2;           // result streams.
  localparam int STRM_ID_W = 1;           // bits of a stream id.
  localparam int DATA_W    = 64;          // beat width.
  localparam int KEEP_W    = DATA_W / 8;  // one keep bit per byte.
  localparam int ADDR_W    = 48;          // host address.
  localparam int LEN_W     = 16;          // transfer and stream byte counts.

  // ****************************************
  // transfer shaping
  // ****************************************
  localparam int TRANSFER_BEATS  = 4;                           // 32 bytes at most.
  localparam int MAX_OUTSTANDING = 4;                           // requests awaiting completion.
  localparam int BEAT_W          = $clog2(TRANSFER_BEATS);      // beat index in a transfer.
  localparam int OUTST_W         = $clog2(MAX_OUTSTANDING + 1); // outstanding counter.

  // ****************************************
  // packed messages
  // ****************************************
  // request is {id, addr, len, final}, so final sits in bit 0.
  localparam int REQ_W    = STRM_ID_W + ADDR_W + LEN_W + 1;
  // notification is {id, total}.
  localparam int NOTIFY_W = STRM_ID_W + LEN_W;

  typedef enum logic [1:0] {
    WR_IDLE   = 2'd0,  // no beat of the stream yet.
    WR_STREAM = 2'd1,  // beats flowing, transfers being cut.
    WR_DRAIN  = 2'd2,  // tlast seen, completions pending.
    WR_NOTIFY = 2'd3   // total offered to the notify port.
  } wr_state_e;

endpackage

// File: output_writer.sv
`timescale 1ns/1ps

module output_writer (
  input  logic                                                         clk,
  input  logic                                                         rst_n,
  // per-stream results in.
  input  logic [out_writer_pkg::N_STRM-1:0][out_writer_pkg::DATA_W-1:0] data_in_tdata,
  input  logic [out_writer_pkg::N_STRM-1:0][out_writer_pkg::KEEP_W-1:0] data_in_tkeep,
  input  logic [out_writer_pkg::N_STRM-1:0]                            data_in_tlast,
  input  logic [out_writer_pkg::N_STRM-1:0]                            data_in_tvalid,
  output logic [out_writer_pkg::N_STRM-1:0]                            data_in_tready,
  // per-stream memory data out.
  output logic [out_writer_pkg::N_STRM-1:0][out_writer_pkg::DATA_W-1:0] data_out_tdata,
  output logic [out_writer_pkg::N_STRM-1:0][out_writer_pkg::KEEP_W-1:0] data_out_tkeep,
  output logic [out_writer_pkg::N_STRM-1:0]                            data_out_tlast,
  output logic [out_writer_pkg::N_STRM-1:0]                            data_out_tvalid,
  input  logic [out_writer_pkg::N_STRM-1:0]                            data_out_tready,
  output logic [out_writer_pkg::N_STRM-1:0][out_writer_pkg::STRM_ID_W-1:0] data_out_tid,
  // per-stream config.
  input  logic [out_writer_pkg::N_STRM-1:0][out_writer_pkg::ADDR_W-1:0] mem_base,
  input  logic [out_writer_pkg::N_STRM-1:0]                            mem_load,
  // shared write request port.
  output logic [out_writer_pkg::REQ_W-1:0]                             sq_wr_data,
  output logic                                                         sq_wr_valid,
  input  logic                                                         sq_wr_ready,
  // shared completion port.
  input  logic [out_writer_pkg::STRM_ID_W-1:0]                         cq_wr_data,
  input  logic                                                         cq_wr_valid,
  // shared notify port.
  output logic [out_writer_pkg::NOTIFY_W-1:0]                          notify_data,
  output logic                                                         notify_valid,
  input  logic                                                         notify_ready
);

  logic [out_writer_pkg::N_STRM-1:0][out_writer_pkg::REQ_W-1:0]    req_data;
  logic [out_writer_pkg::N_STRM-1:0]                               req_valid;
  logic [out_writer_pkg::N_STRM-1:0]                               req_ready;
  logic [out_writer_pkg::N_STRM-1:0]                               cpl_valid;
  logic [out_writer_pkg::N_STRM-1:0][out_writer_pkg::NOTIFY_W-1:0] ntf_data;
  logic [out_writer_pkg::N_STRM-1:0]                               ntf_valid;
  logic [out_writer_pkg::N_STRM-1:0]                               ntf_ready;

  // ****************************************
  // one writer per stream
  // ****************************************
  for (genvar i = 0; i < out_writer_pkg::N_STRM; i++) begin : g_strm
    stream_writer #(
      .STRM_ID (i)
    ) u_stream_writer (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_tdata   (data_in_tdata[i]),
      .in_tkeep   (data_in_tkeep[i]),
      .in_tlast   (data_in_tlast[i]),
      .in_tvalid  (data_in_tvalid[i]),
      .in_tready  (data_in_tready[i]),
      .out_tdata  (data_out_tdata[i]),
      .out_tkeep  (data_out_tkeep[i]),
      .out_tlast  (data_out_tlast[i]),
      .out_tvalid (data_out_tvalid[i]),
      .out_tready (data_out_tready[i]),
      .out_tid    (data_out_tid[i]),
      .mem_base   (mem_base[i]),
      .mem_load   (mem_load[i]),
      .req_data   (req_data[i]),
      .req_valid  (req_valid[i]),
      .req_ready  (req_ready[i]),
      .cpl_valid  (cpl_valid[i]),
      .ntf_data   (ntf_data[i]),
      .ntf_valid  (ntf_valid[i]),
      .ntf_ready  (ntf_ready[i])
    );
  end

  // ****************************************
  // shared ports
  // ****************************************
  rr_arbiter #(
    .N_IN  (out_writer_pkg::N_STRM),
    .MSG_W (out_writer_pkg::REQ_W)
  ) u_sq_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (req_data),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .out_data  (sq_wr_data),
    .out_valid (sq_wr_valid),
    .out_ready (sq_wr_ready)
  );

  rr_arbiter #(
    .N_IN  (out_writer_pkg::N_STRM),
    .MSG_W (out_writer_pkg::NOTIFY_W)
  ) u_notify_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (ntf_data),
    .in_valid  (ntf_valid),
    .in_ready  (ntf_ready),
    .out_data  (notify_data),
    .out_valid (notify_valid),
    .out_ready (notify_ready)
  );

  cq_demux u_cq_demux (
    .clk       (clk),
    .rst_n     (rst_n),
    .cq_data   (cq_wr_data),
    .cq_valid  (cq_wr_valid),
    .cpl_valid (cpl_valid)
  );

endmodule

// File: rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int N_IN  = 2,  // inputs, at least two.
  parameter int MSG_W = 8   // message width.
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [N_IN-1:0][MSG_W-1:0] in_data,
  input  logic [N_IN-1:0]            in_valid,
  output logic [N_IN-1:0]            in_ready,
  output logic [MSG_W-1:0]           out_data,
  output logic                       out_valid,
  input  logic                       out_ready
);

  logic [$clog2(N_IN)-1:0] last_q;   // last granted input.
  logic [$clog2(N_IN)-1:0] gnt_idx;
  logic                    gnt_found;
  logic                    can_load; // output register free next edge.

  assign can_load = !out_valid || out_ready;

  // ****************************************
  // round-robin search
  // ****************************************
  always_comb begin
    int cand;
    gnt_found = 1'b0;
    gnt_idx   = last_q;
    for (int k = 1; k <= N_IN; k++) begin
      cand = (int'(last_q) + k) % N_IN;  // start right after last grant.
      if (!gnt_found && in_valid[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand[$clog2(N_IN)-1:0];
      end
    end
  end

  always_comb begin
    in_ready = '0;
    if (can_load && gnt_found) begin
      in_ready[gnt_idx] = 1'b1;  // grant only into a free register.
    end
  end

  // ****************************************
  // registered output
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      last_q    <= '1;  // first grant goes to input 0.
    end else if (can_load) begin
      out_valid <= gnt_found;
      if (gnt_found) begin
        last_q <= gnt_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_load && gnt_found) begin
      out_data <= in_data[gnt_idx];
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("arbiter output changed while stalled.");

endmodule

// File: stream_writer.sv
`timescale 1ns/1ps

module stream_writer #(
  parameter int STRM_ID = 0  // index of the stream served.
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  // result stream from the accelerator.
  input  logic [out_writer_pkg::DATA_W-1:0]      in_tdata,
  input  logic [out_writer_pkg::KEEP_W-1:0]      in_tkeep,
  input  logic                                   in_tlast,
  input  logic                                   in_tvalid,
  output logic                                   in_tready,
  // memory side data port.
  output logic [out_writer_pkg::DATA_W-1:0]      out_tdata,
  output logic [out_writer_pkg::KEEP_W-1:0]      out_tkeep,
  output logic                                   out_tlast,
  output logic                                   out_tvalid,
  input  logic                                   out_tready,
  output logic [out_writer_pkg::STRM_ID_W-1:0]   out_tid,
  // stream config.
  input  logic [out_writer_pkg::ADDR_W-1:0]      mem_base,
  input  logic                                   mem_load,
  // write requests, completions and notification.
  output logic [out_writer_pkg::REQ_W-1:0]       req_data,
  output logic                                   req_valid,
  input  logic                                   req_ready,
  input  logic                                   cpl_valid,
  output logic [out_writer_pkg::NOTIFY_W-1:0]    ntf_data,
  output logic                                   ntf_valid,
  input  logic                                   ntf_ready
);

  out_writer_pkg::wr_state_e state_q, state_d;

  logic [out_writer_pkg::STRM_ID_W-1:0] strm_id;
  logic [out_writer_pkg::BEAT_W-1:0]    beat_cnt_q;    // beats taken in this transfer.
  logic [out_writer_pkg::LEN_W-1:0]     xfer_bytes_q;  // bytes before the current beat.
  logic [out_writer_pkg::LEN_W-1:0]     beat_bytes;
  logic [out_writer_pkg::LEN_W-1:0]     xfer_len;      // transfer length with this beat.
  logic [out_writer_pkg::ADDR_W-1:0]    next_addr_q;   // host address of next transfer.
  logic [out_writer_pkg::LEN_W-1:0]     total_q;       // stream bytes requested so far.
  logic [out_writer_pkg::OUTST_W-1:0]   outst_q;
  logic                                 req_valid_q;
  logic [out_writer_pkg::ADDR_W-1:0]    req_addr_q;
  logic [out_writer_pkg::LEN_W-1:0]     req_len_q;
  logic                                 req_final_q;
  logic                                 pass_ok;
  logic                                 closing;
  logic                                 beat;
  logic                                 close;

  assign strm_id = STRM_ID[out_writer_pkg::STRM_ID_W-1:0];

  // ****************************************
  // data pass-through and gating
  // ****************************************
  assign closing = in_tlast || (int'(beat_cnt_q) == out_writer_pkg::TRANSFER_BEATS - 1);

  // hold the stream while finishing, at the credit limit, or when a close would overflow.
  assign pass_ok = (state_q == out_writer_pkg::WR_IDLE || state_q == out_writer_pkg::WR_STREAM)
                 && (int'(outst_q) != out_writer_pkg::MAX_OUTSTANDING)
                 && !(req_valid_q && closing);

  assign out_tdata  = in_tdata;
  assign out_tkeep  = in_tkeep;
  assign out_tlast  = in_tlast;
  assign out_tid    = strm_id;
  assign out_tvalid = in_tvalid && pass_ok;
  assign in_tready  = out_tready && pass_ok;

  assign beat  = in_tvalid && in_tready;
  assign close = beat && closing && !mem_load;  // latches a request.

  // only the last beat may be partial.
  assign beat_bytes = in_tlast ? out_writer_pkg::LEN_W'($countones(in_tkeep))
                               : out_writer_pkg::LEN_W'(out_writer_pkg::KEEP_W);
  assign xfer_len   = xfer_bytes_q + beat_bytes;

  // ****************************************
  // transfer cutting and stream address
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt_q   <= '0;
      xfer_bytes_q <= '0;
      next_addr_q  <= '0;
      total_q      <= '0;
    end else if (mem_load) begin
      beat_cnt_q   <= '0;
      xfer_bytes_q <= '0;
      next_addr_q  <= mem_base;  // restart at the new base.
      total_q      <= '0;
    end else if (beat) begin
      if (closing) begin
        beat_cnt_q   <= '0;
        xfer_bytes_q <= '0;
        next_addr_q  <= next_addr_q + out_writer_pkg::ADDR_W'(xfer_len);
        total_q      <= total_q + xfer_len;
      end else begin
        beat_cnt_q   <= beat_cnt_q + 1'b1;
        xfer_bytes_q <= xfer_len;
      end
    end else if (ntf_valid && ntf_ready) begin
      total_q <= '0;  // next stream counts afresh.
    end
  end

  // one request register, refilled only once empty.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid_q <= 1'b0;
    end else if (close) begin
      req_valid_q <= 1'b1;
    end else if (req_ready) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (close) begin
      req_addr_q  <= next_addr_q;
      req_len_q   <= xfer_len;
      req_final_q <= in_tlast;  // last transfer of the stream.
    end
  end

  assign req_data  = {strm_id, req_addr_q, req_len_q, req_final_q};
  assign req_valid = req_valid_q;

  // request in the register counts as outstanding.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= '0;
    end else begin
      case ({close, cpl_valid})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: outst_q <= outst_q;  // none, or both cancel.
      endcase
    end
  end

  // ****************************************
  // stream FSM
  // ****************************************
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      out_writer_pkg::WR_IDLE: begin
        if (beat) begin
          state_d = in_tlast ? out_writer_pkg::WR_DRAIN : out_writer_pkg::WR_STREAM;
        end
      end
      out_writer_pkg::WR_STREAM: begin
        if (beat && in_tlast) begin
          state_d = out_writer_pkg::WR_DRAIN;
        end
      end
      out_writer_pkg::WR_DRAIN: begin
        if (cpl_valid && int'(outst_q) == 1) begin
          state_d = out_writer_pkg::WR_NOTIFY;  // final completion back.
        end
      end
      out_writer_pkg::WR_NOTIFY: begin
        if (ntf_ready) begin
          state_d = out_writer_pkg::WR_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= out_writer_pkg::WR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign ntf_data  = {strm_id, total_q};
  assign ntf_valid = (state_q == out_writer_pkg::WR_NOTIFY);

  // ****************************************
  // checks
  // ****************************************
  a_keep_full: assert property (@(posedge clk) disable iff (!rst_n)
    in_tvalid && !in_tlast |-> &in_tkeep)
    else $error("stream %0d: non-last keep %h is not all ones.", STRM_ID, in_tkeep);

  a_keep_last: assert property (@(posedge clk) disable iff (!rst_n)
    in_tvalid && in_tlast |-> $onehot0(out_writer_pkg::KEEP_W'(in_tkeep + 1'b1)))
    else $error("stream %0d: last keep %h is not contiguous from bit 0.", STRM_ID, in_tkeep);

  // completions never outrun the credit limit.
  a_outst_max: assert property (@(posedge clk) disable iff (!rst_n)
    int'(outst_q) <= out_writer_pkg::MAX_OUTSTANDING)
    else $error("stream %0d: %0d requests outstanding.", STRM_ID, outst_q);

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period.
  end

  initial begin
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // released away from the rising edge.
  end

endmodule

// File: tb_output_writer.sv
`timescale 1ns/1ps

module tb_output_writer;

  localparam int NS = out_writer_pkg::N_STRM;
  localparam int RW = out_writer_pkg::REQ_W;
  localparam int MAXB = 32;  // beats per stream at most.
  localparam int MAX_BEATS = 11 + 11 + 22 * 4 + 24 + 9 + 7;  // all tests together.
  localparam int LIMIT = 200 * MAX_BEATS;

  logic clk, rst_n;
  logic [NS-1:0][63:0] data_in_tdata, data_out_tdata;
  logic [NS-1:0][7:0]  data_in_tkeep, data_out_tkeep;
  logic [NS-1:0] data_in_tlast, data_in_tvalid, data_in_tready;
  logic [NS-1:0] data_out_tlast, data_out_tvalid, data_out_tready, data_out_tid;
  logic [NS-1:0][47:0] mem_base;
  logic [NS-1:0] mem_load;
  logic [RW-1:0] sq_wr_data;
  logic sq_wr_valid, sq_wr_ready, cq_wr_data, cq_wr_valid;
  logic [out_writer_pkg::NOTIFY_W-1:0] notify_data;
  logic notify_valid, notify_ready;

  logic [63:0] stim_data [NS][MAXB];  // beats to drive.
  logic [7:0]  stim_keep [NS][MAXB];
  int          stim_n [NS];
  logic [RW-1:0] exp_req [NS][MAXB];  // expected requests.
  int          exp_req_n [NS];
  logic [15:0] exp_total [NS];
  int got_n [NS], req_n [NS], cpl_n [NS], ntf_n [NS];
  int host_id[$], host_due[$];  // completions waiting in the host.
  int errors = 0, tests = 0, failed = 0, cycles = 0, last_gnt = -1;
  logic [31:0] stim_seed, stall_seed, host_seed;
  bit stalls = 1'b0, cpl_hold = 1'b0;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  output_writer u_output_writer (.*);

  function automatic logic [31:0] lcg(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return {state[15:0], state[31:16]};  // low state bits repeat quickly.
  endfunction

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // ****************************************
  // reference model
  // ****************************************
  function automatic void build_expected(input int s, input logic [47:0] base);
    logic [47:0] addr;
    logic [15:0] bytes;
    int cnt;
    bit last;
    addr = base;
    bytes = '0;
    cnt = 0;
    exp_req_n[s] = 0;
    exp_total[s] = '0;
    for (int i = 0; i < stim_n[s]; i++) begin
      last = (i == stim_n[s] - 1);
      bytes += last ? 16'($countones(stim_keep[s][i])) : 16'd8;  // partial only at the end.
      cnt++;
      if (last || cnt == 4) begin  // transfer closes.
        exp_req[s][exp_req_n[s]] = {1'(s), addr, bytes, last};
        exp_req_n[s]++;
        addr += 48'(bytes);
        exp_total[s] += bytes;
        bytes = '0;
        cnt = 0;
      end
    end
  endfunction

  // ****************************************
  // host model and ready stalls
  // ****************************************
  always @(negedge clk) begin
    sq_wr_ready     <= stalls ? (lcg(stall_seed) % 10 < 7) : 1'b1;
    notify_ready    <= stalls ? (lcg(stall_seed) % 4 != 0) : 1'b1;
    data_out_tready <= stalls ? 2'(lcg(stall_seed) | lcg(stall_seed)) : '1;  // mostly ready.
    if (!cpl_hold && host_id.size() > 0 && cycles >= host_due[0]) begin
      cq_wr_valid <= 1'b1;
      cq_wr_data  <= 1'(host_id.pop_front());
      void'(host_due.pop_front());
    end else begin
      cq_wr_valid <= 1'b0;
    end
  end

  // ****************************************
  // compare process
  // ****************************************
  always @(posedge clk) begin
    int s;
    cycles++;
    for (int k = 0; k < NS; k++) begin
      if (data_out_tvalid[k] && data_out_tready[k]) begin
        check_val("data_out_tdata", data_out_tdata[k], stim_data[k][got_n[k]]);
        check_val("data_out_tkeep", data_out_tkeep[k], stim_keep[k][got_n[k]]);
        check_val("data_out_tlast", data_out_tlast[k], got_n[k] == stim_n[k] - 1);
        check_val("data_out_tid", data_out_tid[k], k);
        got_n[k]++;
      end
    end
    if (sq_wr_valid && sq_wr_ready) begin
      s = int'(sq_wr_data[RW-1]);
      check_val("sq_wr_data", sq_wr_data, exp_req[s][req_n[s]]);
      req_n[s]++;
      host_id.push_back(s);
      host_due.push_back(cycles + 1 + int'(lcg(host_seed) % 8));  // random return delay.
    end
    if (cq_wr_valid) cpl_n[cq_wr_data]++;
    if (notify_valid && notify_ready) begin
      s = int'(notify_data[16]);
      check_val("completions before notify", cpl_n[s], exp_req_n[s]);
      check_val("notify_data total", notify_data[15:0], exp_total[s]);
      ntf_n[s]++;
    end
    // no second grant in a row while the other stream waits.
    if (|u_output_writer.req_ready) begin
      s = u_output_writer.req_ready[1] ? 1 : 0;
      if (s == last_gnt && u_output_writer.req_valid[1-s]) check_val("sq grant", s, 1 - s);
      last_gnt = s;
    end
    if (cycles > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // ****************************************
  // stimulus
  // ****************************************
  task automatic load_stream(input int s, input int len);
    logic [47:0] base;
    base = {16'(s + 1), lcg(stim_seed) & 32'hffff_ffe0};
    stim_n[s] = len;
    for (int i = 0; i < len; i++) begin
      stim_data[s][i] = {lcg(stim_seed), lcg(stim_seed)};
      stim_keep[s][i] = (i == len - 1) ? 8'((16'd2 << (lcg(stim_seed) % 8)) - 1) : 8'hff;
    end
    build_expected(s, base);
    got_n[s] = 0;
    req_n[s] = 0;
    cpl_n[s] = 0;
    ntf_n[s] = 0;
    @(negedge clk);
    mem_base[s] = base;
    mem_load[s] = 1'b1;  // loads the new base and clears totals.
    @(negedge clk);
    mem_load[s] = 1'b0;
  endtask

  task automatic drive_stream(input int s);
    for (int i = 0; i < stim_n[s]; i++) begin
      @(negedge clk);
      data_in_tdata[s]  = stim_data[s][i];
      data_in_tkeep[s]  = stim_keep[s][i];
      data_in_tlast[s]  = (i == stim_n[s] - 1);
      data_in_tvalid[s] = 1'b1;
      @(posedge clk);
      while (!data_in_tready[s]) @(posedge clk);  // beat held until taken.
    end
    @(negedge clk);
    data_in_tvalid[s] = 1'b0;
    data_in_tlast[s]  = 1'b0;
  endtask

  task automatic finish_test(input string name, input logic [1:0] mask);
    int err0;
    err0 = errors;
    for (int s = 0; s < NS; s++) begin
      while (mask[s] && ntf_n[s] == 0) @(posedge clk);  // notify ends the stream.
    end
    repeat (10) @(posedge clk);
    for (int s = 0; s < NS; s++) begin
      if (mask[s]) begin
        check_val("beat count", got_n[s], stim_n[s]);
        check_val("request count", req_n[s], exp_req_n[s]);
        check_val("notify count", ntf_n[s], 1);
      end
    end
    tests++;
    if (errors != err0) failed++;
    $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "errors");
  endtask

  task automatic run_both(input string name, input int len0, input int len1);
    load_stream(0, len0);
    load_stream(1, len1);
    fork
      drive_stream(0);
      drive_stream(1);
    join
    finish_test(name, 2'b11);
  endtask

  initial begin
    data_in_tdata = '0;
    data_in_tkeep = '0;
    data_in_tlast = '0;
    data_in_tvalid = '0;
    data_out_tready = '1;
    mem_base = '0;
    mem_load = '0;
    sq_wr_ready = 1'b1;
    cq_wr_data = 1'b0;
    cq_wr_valid = 1'b0;
    notify_ready = 1'b1;
    stim_seed = 32'hc169;
    stall_seed = lcg(stim_seed);
    host_seed = lcg(stim_seed);
    while (!rst_n) @(posedge clk);
    for (int s = 0; s < NS; s++) begin
      load_stream(s, 1 + int'(lcg(stim_seed) % 11));
      drive_stream(s);
      finish_test($sformatf("single stream %0d", s), 2'(1 << s));
    end
    stalls = 1'b1;
    for (int t = 0; t < 4; t++) begin
      run_both("both streams, stalls", 1 + int'(lcg(stim_seed) % 11),
               1 + int'(lcg(stim_seed) % 11));
    end
    // four requests reach the credit limit and stall the stream.
    cpl_hold = 1'b1;
    load_stream(0, 24);
    fork
      drive_stream(0);
      begin
        while (req_n[0] < 4) @(posedge clk);
        repeat (20) @(posedge clk);
        check_val("beats under credit stall", got_n[0], 16);
        cpl_hold = 1'b0;  // host returns completions.
      end
    join
    finish_test("outstanding limit", 2'b01);
    load_stream(0, 9);
    drive_stream(0);
    finish_test("first base", 2'b01);
    load_stream(0, 7);  // second base.
    drive_stream(0);
    finish_test("reload base", 2'b01);
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
